//--- hdl/refill_pkg.sv
package refill_pkg;

    // bus widths
    localparam int ADDR_W = 32;   // byte address
    localparam int DATA_W = 64;   // one R beat
    localparam int ID_W   = 1;    // enough for the requester index

    // requesters sharing the read port
    // index 0 is the instruction cache, index 1 the data cache
    // the ID on the bus equals this index
    localparam int NUM_REQ = 2;

    // field types
    typedef logic [ADDR_W-1:0] addr_t;   // byte address
    typedef logic [DATA_W-1:0] data_t;   // R data word
    typedef logic [7:0]        len_t;    // beats minus one
    typedef logic [ID_W-1:0]   id_t;     // transaction id
    typedef logic [2:0]        size_t;   // log2 of bytes per beat
    typedef logic [1:0]        resp_t;   // OKAY / EXOKAY / SLVERR / DECERR

    // burst type encoding, only INCR is used on this path
    localparam logic [1:0] BURST_INCR = 2'b01;

    // beat sizes
    // single-beat fetches read one 32-bit word
    localparam size_t SIZE_WORD = 3'd2;

    // multi-beat refills use the full bus width
    localparam size_t SIZE_FULL = size_t'($clog2(DATA_W / 8));

endpackage

//--- hdl/axi_read_if.sv
`timescale 1ns/1ns

// AR and R channels of one AXI read port
interface axi_read_if import refill_pkg::*; ();

    // address channel
    logic        ar_valid;
    logic        ar_ready;
    addr_t       ar_addr;
    id_t         ar_id;
    len_t        ar_len;
    size_t       ar_size;
    logic [1:0]  ar_burst;

    // data channel
    logic        r_valid;
    logic        r_ready;
    data_t       r_data;
    resp_t       r_resp;
    logic        r_last;
    id_t         r_id;

    // requester side
    modport master (
        output ar_valid, ar_addr, ar_id, ar_len, ar_size, ar_burst,
        input  ar_ready,
        input  r_valid, r_data, r_resp, r_last, r_id,
        output r_ready
    );

    // arbiter side, one per requester
    modport slave (
        input  ar_valid, ar_addr, ar_id, ar_len, ar_size, ar_burst,
        output ar_ready,
        output r_valid, r_data, r_resp, r_last, r_id,
        input  r_ready
    );

endinterface

//--- hdl/axi_burst_read_master.sv
`timescale 1ns/1ns

// one INCR burst per cache request with one burst outstanding at a time
module axi_burst_read_master import refill_pkg::*; (
    input  logic        clock,
    input  logic        reset,           // async active low

    // cache side
    input  logic        req_valid_i,     // level request
    input  addr_t       req_addr_i,
    input  len_t        req_len_i,       // beats minus one
    output logic        req_ready_o,     // high only when idle
    output data_t       rdata_o,
    output logic        rdata_valid_o,   // one strobe per beat
    output logic        rdata_last_o,
    output logic        busy_o,

    // bus side towards the arbiter
    axi_read_if.master  axi
);

    // idle encodes as zero
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_AR_WAIT = 2'b01,   // address presented until ar_ready
        ST_R_WAIT  = 2'b11    // collecting beats until r_last
    } state_t;

    state_t state_q;
    state_t state_d;

    addr_t  addr_q;           // latched on acceptance
    len_t   len_q;

    logic   req_take;         // cache request accepted this cycle
    logic   ar_hs;            // address handshake
    logic   r_hs;             // data handshake
    logic   r_done;           // final beat of the burst

    assign req_take = req_valid_i && req_ready_o;
    assign ar_hs    = axi.ar_valid && axi.ar_ready;
    assign r_hs     = axi.r_valid && axi.r_ready;
    assign r_done   = r_hs && axi.r_last;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_take) begin
                    state_d = ST_AR_WAIT;
                end
            end
            ST_AR_WAIT: begin
                if (ar_hs) begin
                    state_d = ST_R_WAIT;
                end
            end
            ST_R_WAIT: begin
                if (r_done) begin
                    state_d = ST_IDLE;   // back to idle on the edge after last
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address and length held for the whole AR phase
    always_ff @(posedge clock) begin
        if (req_take) begin
            addr_q <= req_addr_i;
            len_q  <= req_len_i;
        end
    end

    // AR channel
    assign axi.ar_valid = (state_q == ST_AR_WAIT);   // valid from cycle N+1
    assign axi.ar_addr  = addr_q;
    assign axi.ar_id    = '0;                        // arbiter retags with the port index
    assign axi.ar_len   = len_q;
    assign axi.ar_size  = (len_q == '0) ? SIZE_WORD : SIZE_FULL;  // single word fetch
    assign axi.ar_burst = BURST_INCR;

    // R always accepted in data wait
    assign axi.r_ready  = (state_q == ST_R_WAIT);

    // cache side
    assign req_ready_o   = (state_q == ST_IDLE);
    assign busy_o        = (state_q != ST_IDLE);
    assign rdata_o       = axi.r_data;               // straight from the bus
    assign rdata_valid_o = r_hs;
    assign rdata_last_o  = r_done;                   // only meaningful with valid

endmodule

//--- hdl/axi_read_arbiter.sv
`timescale 1ns/1ns

// merges NUM_REQ read masters onto one AR/R bus
// AR granted round-robin, R routed back by id
module axi_read_arbiter import refill_pkg::*; (
    input  logic        clock,
    input  logic        reset,          // async, active low

    // requester ports, index equals the id used on the bus
    axi_read_if.slave   req [NUM_REQ],

    // external AR channel
    output logic        ar_valid_o,
    input  logic        ar_ready_i,
    output addr_t       ar_addr_o,
    output id_t         ar_id_o,
    output len_t        ar_len_o,
    output size_t       ar_size_o,
    output logic [1:0]  ar_burst_o,

    // external R channel
    input  logic        r_valid_i,
    output logic        r_ready_o,
    input  data_t       r_data_i,
    input  resp_t       r_resp_i,
    input  logic        r_last_i,
    input  id_t         r_id_i
);

    // per-requester copies of the interface fields
    logic        ar_valid_v [NUM_REQ];
    addr_t       ar_addr_a  [NUM_REQ];
    len_t        ar_len_a   [NUM_REQ];
    size_t       ar_size_a  [NUM_REQ];
    logic [1:0]  ar_burst_a [NUM_REQ];
    logic        r_ready_v  [NUM_REQ];

    id_t         rr_q;        // requester favoured on the next tie
    id_t         grant_q;     // grant held while AR is stalled
    logic        lock_q;      // an AR is pending on the bus
    id_t         rr_pick;     // round-robin choice this cycle
    id_t         grant;       // effective grant
    logic        ar_hs;

    genvar i;
    generate
        for (i = 0; i < NUM_REQ; i++) begin : g_req
            assign ar_valid_v[i] = req[i].ar_valid;
            assign ar_addr_a[i]  = req[i].ar_addr;
            assign ar_len_a[i]   = req[i].ar_len;
            assign ar_size_a[i]  = req[i].ar_size;
            assign ar_burst_a[i] = req[i].ar_burst;
            assign r_ready_v[i]  = req[i].r_ready;

            // ready only to the granted master
            assign req[i].ar_ready = ar_ready_i && (grant == id_t'(i));

            // beat goes to the master whose id it carries
            assign req[i].r_valid  = r_valid_i && (r_id_i == id_t'(i));
            assign req[i].r_data   = r_data_i;   // broadcast, qualified by r_valid
            assign req[i].r_resp   = r_resp_i;
            assign req[i].r_last   = r_last_i;
            assign req[i].r_id     = r_id_i;
        end
    endgenerate

    // first requesting master at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        rr_pick = rr_q;
        found   = 1'b0;
        for (int k = 0; k < NUM_REQ; k++) begin
            idx = (int'(rr_q) + k) % NUM_REQ;
            if (!found && ar_valid_v[idx]) begin
                rr_pick = id_t'(idx);
                found   = 1'b1;
            end
        end
    end

    // a stalled AR keeps its grant so valid is never withdrawn
    assign grant = lock_q ? grant_q : rr_pick;

    // AR mux, zero latency
    assign ar_valid_o = ar_valid_v[grant];
    assign ar_addr_o  = ar_addr_a[grant];
    assign ar_id_o    = grant;                    // tag with requester index
    assign ar_len_o   = ar_len_a[grant];
    assign ar_size_o  = ar_size_a[grant];
    assign ar_burst_o = ar_burst_a[grant];

    assign ar_hs = ar_valid_o && ar_ready_i;

    // R ready from the addressed master
    assign r_ready_o = r_ready_v[r_id_i];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rr_q    <= '0;                        // requester 0 first
            grant_q <= '0;
            lock_q  <= 1'b0;
        end else if (ar_hs) begin
            lock_q <= 1'b0;
            // the other master wins the next tie
            if (grant == id_t'(NUM_REQ - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= grant + id_t'(1);
            end
        end else if (ar_valid_o) begin
            lock_q  <= 1'b1;                      // stalled, hold this grant
            grant_q <= grant;
        end
    end

endmodule

//--- hdl/refill_top.sv
`timescale 1ns/1ns

// instruction and data cache refill masters sharing one AXI read port
module refill_top import refill_pkg::*; (
    input  logic        clock,
    input  logic        reset,              // async, active low

    // instruction cache
    input  logic        ic_req_valid_i,
    input  addr_t       ic_req_addr_i,
    input  len_t        ic_req_len_i,
    output logic        ic_req_ready_o,
    output data_t       ic_rdata_o,
    output logic        ic_rdata_valid_o,
    output logic        ic_rdata_last_o,
    output logic        ic_busy_o,

    // data cache
    input  logic        dc_req_valid_i,
    input  addr_t       dc_req_addr_i,
    input  len_t        dc_req_len_i,
    output logic        dc_req_ready_o,
    output data_t       dc_rdata_o,
    output logic        dc_rdata_valid_o,
    output logic        dc_rdata_last_o,
    output logic        dc_busy_o,

    // AXI read port
    output logic        ar_valid_o,
    input  logic        ar_ready_i,
    output addr_t       ar_addr_o,
    output id_t         ar_id_o,
    output len_t        ar_len_o,
    output size_t       ar_size_o,
    output logic [1:0]  ar_burst_o,
    input  logic        r_valid_i,
    output logic        r_ready_o,
    input  data_t       r_data_i,
    input  resp_t       r_resp_i,
    input  logic        r_last_i,
    input  id_t         r_id_i
);

    // [0] icache, [1] dcache
    axi_read_if req_if [NUM_REQ] ();

    axi_burst_read_master ic_master_inst (
        .clock         (clock),
        .reset         (reset),
        .req_valid_i   (ic_req_valid_i),
        .req_addr_i    (ic_req_addr_i),
        .req_len_i     (ic_req_len_i),
        .req_ready_o   (ic_req_ready_o),
        .rdata_o       (ic_rdata_o),
        .rdata_valid_o (ic_rdata_valid_o),
        .rdata_last_o  (ic_rdata_last_o),
        .busy_o        (ic_busy_o),
        .axi           (req_if[0])
    );

    axi_burst_read_master dc_master_inst (
        .clock         (clock),
        .reset         (reset),
        .req_valid_i   (dc_req_valid_i),
        .req_addr_i    (dc_req_addr_i),
        .req_len_i     (dc_req_len_i),
        .req_ready_o   (dc_req_ready_o),
        .rdata_o       (dc_rdata_o),
        .rdata_valid_o (dc_rdata_valid_o),
        .rdata_last_o  (dc_rdata_last_o),
        .busy_o        (dc_busy_o),
        .axi           (req_if[1])
    );

    axi_read_arbiter arbiter_inst (
        .clock      (clock),
        .reset      (reset),
        .req        (req_if),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .ar_id_o    (ar_id_o),       // equals the requester index
        .ar_len_o   (ar_len_o),
        .ar_size_o  (ar_size_o),
        .ar_burst_o (ar_burst_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_data_i   (r_data_i),
        .r_resp_i   (r_resp_i),
        .r_last_i   (r_last_i),
        .r_id_i     (r_id_i)
    );

endmodule

//--- verification/axi_mem_model.sv
`timescale 1ns/1ns

// AXI read slave, answers bursts in AR order with random stalls
module axi_mem_model import refill_pkg::*; #(
    parameter int STALL_MAX = 3          // longest inserted gap in cycles
) (
    input  logic   clock,
    input  logic   reset,                // async, active low
    input  logic   ar_valid_i,
    output logic   ar_ready_o,
    input  addr_t  ar_addr_i,
    input  id_t    ar_id_i,
    input  len_t   ar_len_i,
    output logic   r_valid_o,
    input  logic   r_ready_i,
    output data_t  r_data_o,
    output resp_t  r_resp_o,
    output logic   r_last_o,
    output id_t    r_id_o
);

    addr_t q_addr [$];                   // accepted bursts, oldest first
    len_t  q_len  [$];
    id_t   q_id   [$];
    int    beat;                         // beats sent from the head burst
    int    ar_wait;                      // cycles left with ar_ready low
    int    r_wait;                       // gap before the next beat
    logic  live;                         // reset released at this edge
    logic  ar_hs;
    logic  r_hs;
    int unsigned lcg_state = 62;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;           // low bits cycle too fast
    endfunction

    function automatic int stall_len();
        return int'(lcg_next() % 32'(STALL_MAX + 1));
    endfunction

    // beat data, every address bit shows up in it
    function automatic data_t pattern_of(input addr_t a);
        return {a ^ 32'hc0de_5a5a, ~a};
    endfunction

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = '0;
        r_last_o   = 1'b0;
        r_id_o     = '0;
        beat       = 0;
        ar_wait    = 0;
        r_wait     = 0;
        forever begin
            @(posedge clock);
            live  = reset;
            ar_hs = live && ar_valid_i && ar_ready_o;   // values from before the edge
            r_hs  = live && r_valid_o && r_ready_i;
            if (!live) begin
                q_addr.delete();
                q_len.delete();
                q_id.delete();
                beat    = 0;
                ar_wait = 0;
                r_wait  = 0;
            end
            if (ar_hs) begin
                q_addr.push_back(ar_addr_i);
                q_len.push_back(ar_len_i);
                q_id.push_back(ar_id_i);
                ar_wait = stall_len();
            end
            if (r_hs) begin
                r_wait = stall_len();
                beat++;
                if (r_last_o) begin
                    q_addr.delete(0);            // burst done, next one in AR order
                    q_len.delete(0);
                    q_id.delete(0);
                    beat = 0;
                end
            end
            #1;
            if (ar_wait > 0) begin
                ar_wait--;
                ar_ready_o = 1'b0;
            end else begin
                ar_ready_o = live && (q_addr.size() < NUM_REQ);  // one burst per master
            end
            if (live && r_valid_o && !r_hs) begin
                // beat stays on the bus until taken
            end else if (!live || q_addr.size() == 0 || r_wait > 0) begin
                r_valid_o = 1'b0;
                r_last_o  = 1'b0;
                if (r_wait > 0) r_wait--;
            end else begin
                r_valid_o = 1'b1;
                r_data_o  = pattern_of(q_addr[0] + addr_t'(beat * 8));
                r_last_o  = (beat == int'(q_len[0]));
                r_id_o    = q_id[0];
                r_resp_o  = 2'b00;               // OKAY
            end
        end
    end

endmodule

//--- verification/refill_tb.sv
`timescale 1ns/1ns

module refill_tb import refill_pkg::*; ();

    localparam int STALL_MAX = 3;        // worst gap the memory inserts
    localparam int N_ENTRIES = 8;

    typedef struct packed {
        logic  port;                     // 0 icache, 1 dcache
        addr_t addr;
        len_t  len;
        logic  pair;                     // starts with the next entry on the other port
    } entry_t;

    logic  clock, reset;
    logic  ic_req_valid_i, ic_req_ready_o, ic_rdata_valid_o, ic_rdata_last_o, ic_busy_o;
    logic  dc_req_valid_i, dc_req_ready_o, dc_rdata_valid_o, dc_rdata_last_o, dc_busy_o;
    addr_t ic_req_addr_i, dc_req_addr_i, ar_addr_o;
    len_t  ic_req_len_i, dc_req_len_i, ar_len_o;
    data_t ic_rdata_o, dc_rdata_o, r_data_i;
    logic  ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, r_last_i;
    logic  [1:0] ar_burst_o;
    id_t   ar_id_o, r_id_i;
    size_t ar_size_o;
    resp_t r_resp_i;

    entry_t stim [N_ENTRIES];
    id_t    ar_log [$];                  // AR ids in bus order
    int     cycles = 0;
    int     limit;

    refill_top refill_top_inst (.*);

    axi_mem_model #(.STALL_MAX(STALL_MAX)) mem_inst (
        .clock(clock), .reset(reset),
        .ar_valid_i(ar_valid_o), .ar_ready_o(ar_ready_i),
        .ar_addr_i(ar_addr_o), .ar_id_i(ar_id_o), .ar_len_i(ar_len_o),
        .r_valid_o(r_valid_i), .r_ready_i(r_ready_o), .r_data_o(r_data_i),
        .r_resp_o(r_resp_i), .r_last_o(r_last_i), .r_id_o(r_id_i)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_beat(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input size_t got, input size_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_burst(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // expected data for a byte address
    function automatic data_t expected_beat(input addr_t a);
        return {a ^ 32'hc0de_5a5a, ~a};
    endfunction

    task automatic drive_req(input logic port, input logic valid, input addr_t addr, input len_t len);
        if (port) begin
            dc_req_valid_i = valid;
            dc_req_addr_i  = addr;
            dc_req_len_i   = len;
        end else begin
            ic_req_valid_i = valid;
            ic_req_addr_i  = addr;
            ic_req_len_i   = len;
        end
    endtask

    // one request followed to its last beat
    task automatic run_entry(input entry_t e);
        int    k;
        logic  seen_ar;
        data_t data;
        k       = 0;
        seen_ar = 1'b0;
        drive_req(e.port, 1'b1, e.addr, e.len);
        @(posedge clock);                        // idle master takes it here
        #1 drive_req(e.port, 1'b0, '0, '0);
        while (k <= int'(e.len)) begin
            @(posedge clock);
            check_flag("req_ready_o", e.port ? dc_req_ready_o : ic_req_ready_o, 1'b0);
            check_flag("busy_o", e.port ? dc_busy_o : ic_busy_o, 1'b1);
            if (ar_valid_o && ar_ready_i && ar_addr_o == e.addr) begin
                check_id("ar_id_o", ar_id_o, id_t'(e.port));
                check_len("ar_len_o", ar_len_o, e.len);
                // 4-byte word for one beat, whole 8-byte bus otherwise
                check_size("ar_size_o", ar_size_o, (e.len == 8'd0) ? 3'd2 : 3'd3);
                check_burst("ar_burst_o", ar_burst_o, 2'b01);   // AXI INCR
                seen_ar = 1'b1;
            end
            if (r_valid_i && r_id_i == id_t'(e.port)) begin
                check_flag("r_ready_o", r_ready_o, 1'b1);     // data wait never pushes back
            end
            if (e.port ? dc_rdata_valid_o : ic_rdata_valid_o) begin
                if (!seen_ar) fail_run("a read beat arrived before its address transfer");
                data = e.port ? dc_rdata_o : ic_rdata_o;
                check_beat("rdata_o", data, expected_beat(e.addr + addr_t'(k * 8)));
                check_last("rdata_last_o", e.port ? dc_rdata_last_o : ic_rdata_last_o,
                           k == int'(e.len));
                k++;
            end
        end
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > limit) fail_run("timeout, a burst did not finish within the cycle limit");
        if (reset && ar_valid_o && ar_ready_i) ar_log.push_back(ar_id_o);
    end

    initial begin
        int   i;
        int   n_ar;
        logic last_ar;                           // port of the latest AR transfer
        reset = 1'b0;
        drive_req(1'b0, 1'b0, '0, '0);
        drive_req(1'b1, 1'b0, '0, '0);
        stim = '{
            '{1'b0, 32'h0000_1000, 8'd0,  1'b0},   // single-word fetch
            '{1'b1, 32'h0000_2000, 8'd7,  1'b0},   // 8-beat line refill
            '{1'b0, 32'h0000_3000, 8'd3,  1'b1},
            '{1'b1, 32'h0000_4000, 8'd7,  1'b0},
            '{1'b0, 32'h0000_6008, 8'd0,  1'b0},   // leaves the pointer on dcache
            '{1'b1, 32'h0000_5040, 8'd1,  1'b1},
            '{1'b0, 32'h0001_0100, 8'd7,  1'b0},
            '{1'b1, 32'h8000_0010, 8'd15, 1'b0}
        };
        last_ar = 1'b1;                          // reset pointer favours icache
        limit = 50;                              // reset plus slack
        foreach (stim[j]) limit += (int'(stim[j].len) + 1) * (STALL_MAX + 1) + STALL_MAX + 6;
        repeat (2) @(posedge clock);
        #1 reset = 1'b1;
        @(posedge clock);
        check_flag("ic_req_ready_o", ic_req_ready_o, 1'b1);
        check_flag("dc_req_ready_o", dc_req_ready_o, 1'b1);
        check_flag("ar_valid_o", ar_valid_o, 1'b0);
        check_flag("ic_busy_o", ic_busy_o, 1'b0);
        check_flag("dc_busy_o", dc_busy_o, 1'b0);
        #1;
        i = 0;
        while (i < N_ENTRIES) begin
            if (stim[i].pair) begin
                n_ar = ar_log.size();
                fork
                    run_entry(stim[i]);
                    run_entry(stim[i + 1]);
                join
                // port that did not go last wins the tie
                check_id("tie ar_id_o", ar_log[n_ar], id_t'(~last_ar));
                // loser goes second and leaves last_ar as it was
                i += 2;
            end else begin
                run_entry(stim[i]);
                last_ar = stim[i].port;
                i += 1;
            end
            #1;
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- build.f
hdl/refill_pkg.sv
hdl/axi_read_if.sv
hdl/axi_burst_read_master.sv
hdl/axi_read_arbiter.sv
hdl/refill_top.sv
verification/axi_mem_model.sv
verification/refill_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       ?= refill_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -q -F '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q -F '>>> PASS' $(LOG); then echo "simulation gave no verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
